// ==== calc_top.f ====
src/calc_pkg.sv
src/calc_issue.sv
src/calc_pipe_int.sv
src/calc_pipe_mul.sv
src/calc_retire.sv
src/calc_top.sv
test/calc_clk_gen.sv
test/calc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= calc_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0 --timescale 1ns/100ps
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulator printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/calc_tb.sv ====
`timescale 1ns/100ps

module calc_tb;

  import calc_pkg::*;

  localparam int latency_lp     = 4;
  localparam int squash_slots_lp = 4;
  localparam int idle_cycles_lp = 3;
  localparam int rand_rows_lp   = 60;
  localparam int num_regs_lp    = 1 << reg_addr_width_gp;
  localparam int pc_base_lp     = 'h100;

  typedef struct packed
  {
    logic                         v;
    logic [3:0]                   op;
    logic [reg_addr_width_gp-1:0] rd;
    logic                         rd_w;
    logic [reg_addr_width_gp-1:0] rs1;
    logic                         rs1_r;
    logic [reg_addr_width_gp-1:0] rs2;
    logic                         rs2_r;
    logic [dword_width_gp-1:0]    imm1;
    logic [dword_width_gp-1:0]    imm2;
  } stim_row_s;

  typedef struct packed
  {
    logic                         commit_v;
    logic                         illegal;
    logic [pc_width_gp-1:0]       pc;
    logic                         w_v;
    logic [reg_addr_width_gp-1:0] rd;
    logic [dword_width_gp-1:0]    data;
  } expect_s;

  logic               clk;
  logic               rst_n;
  calc_dispatch_pkt_s dispatch_pkt;
  calc_wb_pkt_s       wb_pkt;
  calc_commit_pkt_s   commit_pkt;

  stim_row_s                 stim_q[$];
  expect_s                   expect_q[$];
  // Environment register file that the writeback port updates
  logic [dword_width_gp-1:0] env_rf [num_regs_lp];
  logic [dword_width_gp-1:0] model_rf [num_regs_lp];
  int                        flush_cnt;
  integer                    seed;
  int                        cycle_cnt = 0;
  int                        cycle_limit = 0;

  calc_clk_gen u_clk_gen
    (.clk_o(clk)
     ,.rst_n_o(rst_n)
     );

  calc_top u_calc_top
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.dispatch_pkt_i(dispatch_pkt)
     ,.wb_pkt_o(wb_pkt)
     ,.commit_pkt_o(commit_pkt)
     );

  function automatic logic [dword_width_gp-1:0] alu_model(input logic [3:0] op,
                                                          input logic [dword_width_gp-1:0] a,
                                                          input logic [dword_width_gp-1:0] b);
    case (op)
      e_op_add:
        return a + b;
      e_op_sub:
        return a - b;
      e_op_and:
        return a & b;
      e_op_or:
        return a | b;
      e_op_xor:
        return a ^ b;
      e_op_slt:
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      e_op_mul:
        return a * b;
      default:
        return '0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("error: %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input int v, input logic [3:0] op, input int rd, input int rd_w,
                         input int rs1, input int rs1_r, input int rs2, input int rs2_r,
                         input logic [31:0] imm1, input logic [31:0] imm2);
    stim_row_s row;
    row.v     = (v != 0);
    row.op    = op;
    row.rd    = 5'(rd);
    row.rd_w  = (rd_w != 0);
    row.rs1   = 5'(rs1);
    row.rs1_r = (rs1_r != 0);
    row.rs2   = 5'(rs2);
    row.rs2_r = (rs2_r != 0);
    row.imm1  = imm1;
    row.imm2  = imm2;
    stim_q.push_back(row);
  endtask

  task automatic add_random_row();
    integer    rnd;
    stim_row_s row;
    int        n;
    rnd       = $random(seed);
    row.v     = (rnd[11:8] != 4'h0);
    row.op    = (rnd[7:4] == 4'h0) ? 4'hc : rnd[3:0] % 4'd7;
    // Few registers so that dependencies are frequent
    row.rd    = {2'b00, rnd[14:12]};
    row.rd_w  = rnd[15] | rnd[16];
    row.rs1   = {2'b00, rnd[19:17]};
    row.rs1_r = rnd[20] | rnd[21];
    row.rs2   = {2'b00, rnd[24:22]};
    row.rs2_r = rnd[25] | rnd[26];
    row.imm1  = $random(seed);
    row.imm2  = $random(seed);
    // No read of a multiply destination in the two slots after it
    n = stim_q.size();
    for (int k = 1; k <= 2; k++)
    begin
      if (n >= k && stim_q[n-k].op == e_op_mul)
      begin
        if (stim_q[n-k].rd == row.rs1)
          row.rs1_r = 1'b0;
        if (stim_q[n-k].rd == row.rs2)
          row.rs2_r = 1'b0;
      end
    end
    stim_q.push_back(row);
  endtask

  task automatic build_table();
    // Integer opcodes on plain operands
    add_row(1, e_op_add, 1, 1, 0, 0, 0, 0, 32'd5, 32'd7);
    add_row(1, e_op_sub, 2, 1, 0, 0, 0, 0, 32'd3, 32'd10);
    add_row(1, e_op_and, 3, 1, 0, 0, 0, 0, 32'hf0f0_1234, 32'hff00_ff00);
    add_row(1, e_op_or, 4, 1, 0, 0, 0, 0, 32'h1200_0034, 32'h0056_7800);
    add_row(1, e_op_xor, 5, 1, 0, 0, 0, 0, 32'haaaa_5555, 32'hffff_0000);
    add_row(1, e_op_slt, 6, 1, 0, 0, 0, 0, 32'(-5), 32'd3);
    add_row(1, e_op_slt, 7, 1, 0, 0, 0, 0, 32'd5, 32'(-3));
    // Dependent chain that needs forwarding
    add_row(1, e_op_add, 8, 1, 1, 1, 2, 1, 32'd0, 32'd0);
    add_row(1, e_op_add, 9, 1, 8, 1, 0, 0, 32'd0, 32'd100);
    add_row(1, e_op_sub, 10, 1, 9, 1, 8, 1, 32'd0, 32'd0);
    add_row(1, e_op_xor, 11, 1, 10, 1, 9, 1, 32'd0, 32'd0);
    add_row(1, e_op_or, 12, 1, 11, 1, 8, 1, 32'd0, 32'd0);
    add_row(0, e_op_add, 0, 0, 0, 0, 0, 0, 32'd0, 32'd0);
    // Multiplies with readers three slots later
    add_row(1, e_op_mul, 13, 1, 0, 0, 0, 0, 32'd1234, 32'd5678);
    add_row(1, e_op_mul, 14, 1, 0, 0, 0, 0, 32'h1234_5678, 32'h9abc_def0);
    add_row(1, e_op_add, 15, 1, 0, 0, 0, 0, 32'd11, 32'd22);
    add_row(1, e_op_add, 16, 1, 13, 1, 15, 1, 32'd0, 32'd0);
    add_row(1, e_op_add, 17, 1, 14, 1, 0, 0, 32'd0, 32'd1);
    // Undefined opcode followed by four slots that get squashed
    add_row(1, 4'hb, 18, 1, 0, 0, 0, 0, 32'd1, 32'd2);
    add_row(1, e_op_add, 19, 1, 0, 0, 0, 0, 32'd1, 32'd1);
    add_row(1, e_op_add, 1, 1, 0, 0, 0, 0, 32'd99, 32'd1);
    add_row(1, e_op_mul, 20, 1, 0, 0, 0, 0, 32'd3, 32'd3);
    add_row(1, e_op_add, 21, 1, 18, 1, 0, 0, 32'd0, 32'd0);
    add_row(1, e_op_add, 22, 1, 1, 1, 19, 1, 32'd0, 32'd0);
    add_row(1, e_op_sub, 23, 1, 22, 1, 1, 1, 32'd0, 32'd0);
    repeat (rand_rows_lp)
      add_random_row();
  endtask

  // Drives one row and predicts what it retires as
  task automatic drive_row(input int idx);
    stim_row_s                 row;
    expect_s                   exp;
    logic [dword_width_gp-1:0] op_a;
    logic [dword_width_gp-1:0] op_b;
    row                   = stim_q[idx];
    dispatch_pkt.v        = row.v;
    dispatch_pkt.op       = calc_op_e'(row.op);
    dispatch_pkt.pc       = 16'(pc_base_lp + 4 * idx);
    dispatch_pkt.rd_addr  = row.rd;
    dispatch_pkt.rd_w_v   = row.rd_w;
    dispatch_pkt.rs1_addr = row.rs1;
    dispatch_pkt.rs1_r_v  = row.rs1_r;
    dispatch_pkt.rs2_addr = row.rs2;
    dispatch_pkt.rs2_r_v  = row.rs2_r;
    dispatch_pkt.rs1      = row.rs1_r ? env_rf[row.rs1] : row.imm1;
    dispatch_pkt.rs2      = row.rs2_r ? env_rf[row.rs2] : row.imm2;
    op_a   = row.rs1_r ? model_rf[row.rs1] : row.imm1;
    op_b   = row.rs2_r ? model_rf[row.rs2] : row.imm2;
    exp    = '0;
    exp.pc = 16'(pc_base_lp + 4 * idx);
    if (flush_cnt > 0)
      flush_cnt--;
    else if (row.v)
    begin
      exp.commit_v = 1'b1;
      exp.illegal  = (row.op > 4'h6);
      if (exp.illegal)
        flush_cnt = squash_slots_lp;
      else if (row.rd_w)
      begin
        exp.w_v  = 1'b1;
        exp.rd   = row.rd;
        exp.data = alu_model(row.op, op_a, op_b);
        model_rf[row.rd] = exp.data;
      end
    end
    expect_q.push_back(exp);
  endtask

  task automatic check_outputs(input expect_s exp);
    check_value("commit valid", 32'(commit_pkt.v), 32'(exp.commit_v));
    if (exp.commit_v)
    begin
      check_value("commit illegal", 32'(commit_pkt.illegal), 32'(exp.illegal));
      check_value("commit pc", 32'(commit_pkt.pc), 32'(exp.pc));
    end
    check_value("writeback valid", 32'(wb_pkt.w_v), 32'(exp.w_v));
    if (exp.w_v)
    begin
      check_value("writeback rd", 32'(wb_pkt.rd_addr), 32'(exp.rd));
      check_value("writeback data", wb_pkt.rd_data, exp.data);
    end
  endtask

  initial
  begin
    seed         = 82;
    flush_cnt    = 0;
    dispatch_pkt = '0;
    for (int i = 0; i < num_regs_lp; i++)
    begin
      env_rf[i]   = 32'h5a00_0000 ^ (i * 32'h0101_0101);
      model_rf[i] = env_rf[i];
    end
    build_table();
    cycle_limit = stim_q.size() + 20;
    @(posedge rst_n);
    repeat (idle_cycles_lp)
    begin
      @(negedge clk);
      check_outputs('0);
    end
    // Each falling edge shows the row dispatched four edges earlier
    for (int j = 0; j < stim_q.size() + latency_lp; j++)
    begin
      @(negedge clk);
      if (j >= latency_lp)
        check_outputs(expect_q[j-latency_lp]);
      else
        check_outputs('0);
      if (wb_pkt.w_v)
        env_rf[wb_pkt.rd_addr] = wb_pkt.rd_data;
      if (j < stim_q.size())
        drive_row(j);
      else
        dispatch_pkt = '0;
    end
    $display("NO ERRORS");
    $finish;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout: the test did not end within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

endmodule

// ==== test/calc_clk_gen.sv ====
`timescale 1ns/100ps

module calc_clk_gen
  (output logic clk_o
   , output logic rst_n_o
   );

  localparam int half_period_lp  = 20;
  localparam int reset_cycles_lp = 8;

  initial
  begin
    clk_o = 1'b0;
    forever
      #half_period_lp clk_o = ~clk_o;
  end

  // Reset leaves on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_lp)
      @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== src/calc_top.sv ====
`timescale 1ns/100ps

module calc_top
  (input  logic                         clk_i
   , input  logic                       rst_n_i
   , input  calc_pkg::calc_dispatch_pkt_s dispatch_pkt_i
   , output calc_pkg::calc_wb_pkt_s     wb_pkt_o
   , output calc_pkg::calc_commit_pkt_s commit_pkt_o
   );

  import calc_pkg::*;

  calc_reservation_s              reservation;
  calc_wb_pkt_s                   int_wb;
  calc_wb_pkt_s                   mul_wb;
  calc_wb_pkt_s [2:0]             comp_r;
  logic [2:0][dword_width_gp-1:0] fwd_data;
  logic                           illegal;
  logic                           flush;

  calc_issue u_issue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.flush_i(flush)
     ,.int_wb_i(int_wb)
     ,.comp_r_i(comp_r)
     ,.fwd_i(fwd_data)
     ,.reservation_o(reservation)
     );

  // Integer pipe, result in the same cycle
  calc_pipe_int u_pipe_int
    (.reservation_i(reservation)
     ,.flush_i(flush)
     ,.int_wb_o(int_wb)
     ,.illegal_o(illegal)
     );

  // Multiply pipe, result one cycle later
  calc_pipe_mul u_pipe_mul
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.reservation_i(reservation)
     ,.flush_i(flush)
     ,.mul_wb_o(mul_wb)
     );

  calc_retire u_retire
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.reservation_i(reservation)
     ,.int_wb_i(int_wb)
     ,.mul_wb_i(mul_wb)
     ,.illegal_i(illegal)
     ,.comp_r_o(comp_r)
     ,.fwd_o(fwd_data)
     ,.wb_pkt_o(wb_pkt_o)
     ,.commit_pkt_o(commit_pkt_o)
     ,.flush_o(flush)
     );

endmodule

// ==== src/calc_retire.sv ====
`timescale 1ns/100ps

module calc_retire
  (input  logic                                       clk_i
   , input  logic                                     rst_n_i
   , input  calc_pkg::calc_reservation_s              reservation_i
   , input  calc_pkg::calc_wb_pkt_s                   int_wb_i
   , input  calc_pkg::calc_wb_pkt_s                   mul_wb_i
   , input  logic                                     illegal_i
   , output calc_pkg::calc_wb_pkt_s [2:0]             comp_r_o
   , output logic [2:0][calc_pkg::dword_width_gp-1:0] fwd_o
   , output calc_pkg::calc_wb_pkt_s                   wb_pkt_o
   , output calc_pkg::calc_commit_pkt_s               commit_pkt_o
   , output logic                                     flush_o
   );

  import calc_pkg::*;

  localparam int stage_els_lp = 3;

  calc_exc_stage_s [stage_els_lp-1:0] exc_stage_n;
  calc_exc_stage_s [stage_els_lp-1:0] exc_stage_r;
  // Top entry is the last stage as it leaves, needed for forwarding only
  calc_wb_pkt_s [stage_els_lp:0]      comp_stage_n;
  calc_wb_pkt_s [stage_els_lp-1:0]    comp_stage_r;

  always_comb
  begin
    exc_stage_n[0].v       = reservation_i.v;
    exc_stage_n[0].illegal = illegal_i;
    exc_stage_n[0].pc      = reservation_i.pc;
    for (int i = 1; i < stage_els_lp; i++)
      exc_stage_n[i] = exc_stage_r[i-1];
    // Everything younger than a retiring illegal instruction is dropped
    for (int i = 0; i < stage_els_lp; i++)
      exc_stage_n[i].v &= ~flush_o;
  end

  always_comb
  begin
    comp_stage_n[0].w_v     = reservation_i.rd_w_v & ~illegal_i;
    comp_stage_n[0].rd_addr = reservation_i.rd_addr;
    comp_stage_n[0].rd_data = int_wb_i.w_v ? int_wb_i.rd_data : '0;
    for (int i = 1; i <= stage_els_lp; i++)
      comp_stage_n[i] = comp_stage_r[i-1];
    // Multiply result joins its instruction one stage later
    comp_stage_n[1].rd_data |= mul_wb_i.w_v ? mul_wb_i.rd_data : '0;
    for (int i = 0; i < stage_els_lp; i++)
      comp_stage_n[i].w_v &= exc_stage_n[i].v;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      exc_stage_r  <= '0;
      comp_stage_r <= '0;
    end
    else
    begin
      exc_stage_r  <= exc_stage_n;
      comp_stage_r <= comp_stage_n[stage_els_lp-1:0];
    end
  end

  // Data each registered stage holds once this cycle's results are merged
  for (genvar i = 0; i < stage_els_lp; i++)
  begin : g_fwd
    assign fwd_o[i] = comp_stage_n[i+1].rd_data;
  end

  assign comp_r_o = comp_stage_r;
  assign wb_pkt_o = comp_stage_r[stage_els_lp-1];

  always_comb
  begin
    commit_pkt_o.v       = exc_stage_r[stage_els_lp-1].v;
    commit_pkt_o.illegal = exc_stage_r[stage_els_lp-1].illegal;
    commit_pkt_o.pc      = exc_stage_r[stage_els_lp-1].pc;
  end

  assign flush_o = exc_stage_r[stage_els_lp-1].v & exc_stage_r[stage_els_lp-1].illegal;

  // The multiply lands on its own entry, which carries no integer result
  mul_int_collision_a:
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mul_wb_i.w_v |-> exc_stage_r[0].v && comp_stage_r[0].w_v
                       && (comp_stage_r[0].rd_addr == mul_wb_i.rd_addr)
                       && (comp_stage_r[0].rd_data == '0));

endmodule

// ==== src/calc_pipe_mul.sv ====
`timescale 1ns/100ps

module calc_pipe_mul
  (input  logic                        clk_i
   , input  logic                      rst_n_i
   , input  calc_pkg::calc_reservation_s reservation_i
   , input  logic                      flush_i
   , output calc_pkg::calc_wb_pkt_s    mul_wb_o
   );

  import calc_pkg::*;

  logic                         mul_v_n;
  logic                         mul_v_r;
  logic [dword_width_gp-1:0]    product_n;
  logic [dword_width_gp-1:0]    product_r;
  logic [reg_addr_width_gp-1:0] rd_addr_r;

  assign mul_v_n = reservation_i.v & ~flush_i & reservation_i.rd_w_v
                   & (reservation_i.op == e_op_mul);

  // Only the low word of the product is kept
  assign product_n = reservation_i.rs1 * reservation_i.rs2;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mul_v_r <= 1'b0;
    else
      mul_v_r <= mul_v_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (mul_v_n)
    begin
      product_r <= product_n;
      rd_addr_r <= reservation_i.rd_addr;
    end
  end

  // A flush kills the product that would land in stage 1 this cycle
  always_comb
  begin
    mul_wb_o.w_v     = mul_v_r & ~flush_i;
    mul_wb_o.rd_addr = rd_addr_r;
    mul_wb_o.rd_data = product_r;
  end

endmodule

// ==== src/calc_pipe_int.sv ====
`timescale 1ns/100ps

module calc_pipe_int
  (input  calc_pkg::calc_reservation_s reservation_i
   , input  logic                      flush_i
   , output calc_pkg::calc_wb_pkt_s    int_wb_o
   , output logic                      illegal_o
   );

  import calc_pkg::*;

  logic [dword_width_gp-1:0] alu_result;
  logic                      int_op;
  logic                      undef_op;
  logic                      lt_signed;

  assign lt_signed = $signed(reservation_i.rs1) < $signed(reservation_i.rs2);

  always_comb
  begin
    alu_result = '0;
    int_op     = 1'b1;
    undef_op   = 1'b0;
    case (reservation_i.op)
      e_op_add:
        alu_result = reservation_i.rs1 + reservation_i.rs2;
      e_op_sub:
        alu_result = reservation_i.rs1 - reservation_i.rs2;
      e_op_and:
        alu_result = reservation_i.rs1 & reservation_i.rs2;
      e_op_or:
        alu_result = reservation_i.rs1 | reservation_i.rs2;
      e_op_xor:
        alu_result = reservation_i.rs1 ^ reservation_i.rs2;
      e_op_slt:
        alu_result = {{(dword_width_gp-1){1'b0}}, lt_signed};
      // Handled by the multiply pipe
      e_op_mul:
        int_op = 1'b0;
      default:
      begin
        int_op   = 1'b0;
        undef_op = 1'b1;
      end
    endcase
  end

  assign illegal_o = reservation_i.v & undef_op;

  always_comb
  begin
    int_wb_o.w_v     = reservation_i.v & ~flush_i & int_op & reservation_i.rd_w_v;
    int_wb_o.rd_addr = reservation_i.rd_addr;
    int_wb_o.rd_data = alu_result;
  end

endmodule

// ==== src/calc_issue.sv ====
`timescale 1ns/100ps

module calc_issue
  (input  logic                                       clk_i
   , input  logic                                     rst_n_i
   , input  calc_pkg::calc_dispatch_pkt_s             dispatch_pkt_i
   , input  logic                                     flush_i
   , input  calc_pkg::calc_wb_pkt_s                   int_wb_i
   , input  calc_pkg::calc_wb_pkt_s [2:0]             comp_r_i
   , input  logic [2:0][calc_pkg::dword_width_gp-1:0] fwd_i
   , output calc_pkg::calc_reservation_s              reservation_o
   );

  import calc_pkg::*;

  // Slot 0 is the instruction in the reservation, slots 1 to 3 are completion stages
  localparam int src_els_lp = 4;

  calc_wb_pkt_s [src_els_lp-1:0]              src_pkt;
  logic [src_els_lp-1:0][dword_width_gp-1:0]  src_data;
  logic [src_els_lp-1:0]                      match_rs1;
  logic [src_els_lp-1:0]                      match_rs2;
  logic [dword_width_gp-1:0]                  bypass_rs1;
  logic [dword_width_gp-1:0]                  bypass_rs2;
  calc_reservation_s                          reservation_n;
  calc_reservation_s                          reservation_r;
  logic                                       res_mul_v;
  logic                                       mul_s0_r;
  logic                                       mul_hit_rs1;
  logic                                       mul_hit_rs2;

  assign src_pkt  = {comp_r_i, int_wb_i};
  assign src_data = {fwd_i, int_wb_i.rd_data};

  for (genvar i = 0; i < src_els_lp; i++)
  begin : g_match
    assign match_rs1[i] = dispatch_pkt_i.rs1_r_v & src_pkt[i].w_v
                          & (src_pkt[i].rd_addr == dispatch_pkt_i.rs1_addr);
    assign match_rs2[i] = dispatch_pkt_i.rs2_r_v & src_pkt[i].w_v
                          & (src_pkt[i].rd_addr == dispatch_pkt_i.rs2_addr);
  end

  always_comb
  begin
    bypass_rs1 = dispatch_pkt_i.rs1;
    bypass_rs2 = dispatch_pkt_i.rs2;
    // Walk from oldest to youngest so the youngest match wins
    for (int i = src_els_lp-1; i >= 0; i--)
    begin
      if (match_rs1[i])
        bypass_rs1 = src_data[i];
      if (match_rs2[i])
        bypass_rs2 = src_data[i];
    end
  end

  always_comb
  begin
    reservation_n.v       = dispatch_pkt_i.v & ~flush_i;
    reservation_n.op      = dispatch_pkt_i.op;
    reservation_n.pc      = dispatch_pkt_i.pc;
    reservation_n.rd_addr = dispatch_pkt_i.rd_addr;
    reservation_n.rd_w_v  = dispatch_pkt_i.rd_w_v;
    reservation_n.rs1     = bypass_rs1;
    reservation_n.rs2     = bypass_rs2;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reservation_r <= '0;
      mul_s0_r      <= 1'b0;
    end
    else
    begin
      reservation_r <= reservation_n;
      mul_s0_r      <= res_mul_v & ~flush_i;
    end
  end

  assign reservation_o = reservation_r;

  // Multiply destinations still without data
  assign res_mul_v   = reservation_r.v & reservation_r.rd_w_v & (reservation_r.op == e_op_mul);
  assign mul_hit_rs1 = (res_mul_v & (reservation_r.rd_addr == dispatch_pkt_i.rs1_addr))
                       | (mul_s0_r & comp_r_i[0].w_v
                          & (comp_r_i[0].rd_addr == dispatch_pkt_i.rs1_addr));
  assign mul_hit_rs2 = (res_mul_v & (reservation_r.rd_addr == dispatch_pkt_i.rs2_addr))
                       | (mul_s0_r & comp_r_i[0].w_v
                          & (comp_r_i[0].rd_addr == dispatch_pkt_i.rs2_addr));

  mul_read_hazard_a:
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dispatch_pkt_i.v & ~flush_i)
        |-> !(dispatch_pkt_i.rs1_r_v & mul_hit_rs1) && !(dispatch_pkt_i.rs2_r_v & mul_hit_rs2));

endmodule

// ==== src/calc_pkg.sv ====
package calc_pkg;

  localparam int dword_width_gp    = 32;
  localparam int reg_addr_width_gp = 5;
  localparam int pc_width_gp       = 16;

  // Codes 7 to 15 are undefined and commit as illegal
  typedef enum logic [3:0]
  {
    e_op_add   = 4'h0
    ,e_op_sub  = 4'h1
    ,e_op_and  = 4'h2
    ,e_op_or   = 4'h3
    ,e_op_xor  = 4'h4
    ,e_op_slt  = 4'h5
    ,e_op_mul  = 4'h6
  } calc_op_e;

  typedef struct packed
  {
    logic                         v;
    calc_op_e                     op;
    logic [pc_width_gp-1:0]       pc;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic                         rd_w_v;
    logic [reg_addr_width_gp-1:0] rs1_addr;
    logic                         rs1_r_v;
    logic [reg_addr_width_gp-1:0] rs2_addr;
    logic                         rs2_r_v;
    logic [dword_width_gp-1:0]    rs1;
    logic [dword_width_gp-1:0]    rs2;
  } calc_dispatch_pkt_s;

  // Operands here are already bypassed
  typedef struct packed
  {
    logic                         v;
    calc_op_e                     op;
    logic [pc_width_gp-1:0]       pc;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic                         rd_w_v;
    logic [dword_width_gp-1:0]    rs1;
    logic [dword_width_gp-1:0]    rs2;
  } calc_reservation_s;

  typedef struct packed
  {
    logic                         w_v;
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic [dword_width_gp-1:0]    rd_data;
  } calc_wb_pkt_s;

  typedef struct packed
  {
    logic                   v;
    logic                   illegal;
    logic [pc_width_gp-1:0] pc;
  } calc_exc_stage_s;

  typedef struct packed
  {
    logic                   v;
    logic                   illegal;
    logic [pc_width_gp-1:0] pc;
  } calc_commit_pkt_s;

endpackage
